// File: vlog.f
+incdir+include
logic/emesh_pkg.sv
logic/cfg_access.sv
logic/cfg_regs.sv
logic/dma_regs.sv
logic/mmu_table.sv
logic/cfg_subsystem.sv
bench/cfg_subsystem_tb.sv

// File: Bender.yml
package:
  name: cfg_subsystem

sources:
  # rtl, package first
  - logic/emesh_pkg.sv
  - logic/cfg_access.sv
  - logic/cfg_regs.sv
  - logic/dma_regs.sv
  - logic/mmu_table.sv
  - logic/cfg_subsystem.sv

  # testbench with the reference model header
  - target: test
    include_dirs:
      - include
    files:
      - bench/cfg_subsystem_tb.sv

// File: include/cfg_model.svh
`ifndef CFG_MODEL_SVH
`define CFG_MODEL_SVH

// shadow copies of the three register groups
data_t       model_cfg [16];
data_t       model_dma [8];
logic [63:0] model_mmu [32];

// all storage comes out of reset as zero
function automatic void model_reset();
   foreach (model_cfg[i]) model_cfg[i] = '0;
   foreach (model_dma[i]) model_dma[i] = '0;
   foreach (model_mmu[i]) model_mmu[i] = '0;
endfunction

// applies one accepted packet to the shadow state
// returns 1 when an output packet is expected, placed in exp_pkt
function automatic logic model_apply(input emesh_packet_t pkt, input chip_id_t id,
                                     input logic rx_side, output emesh_packet_t exp_pkt);
   logic        match;
   logic        cfg_hit;
   logic        dma_hit;
   logic        mmu_hit;
   logic [63:0] rdata;
   match   = (pkt.dstaddr[31:20] == id);
   cfg_hit = match && (pkt.dstaddr[19:16] == region_cfg)
             && (pkt.dstaddr[10:8] == {group_cfg_lsb2, rx_side});
   dma_hit = match && (pkt.dstaddr[19:16] == region_cfg)
             && (pkt.dstaddr[10:8] == group_dma) && (pkt.dstaddr[5] == rx_side);
   mmu_hit = match && (pkt.dstaddr[19:16] == region_mmu) && (pkt.dstaddr[15] == rx_side);
   rdata   = '0;
   exp_pkt = pkt;
   exp_pkt.reserved = 1'b0;
   // foreign id is dropped
   if (!match)
      return 1'b0;
   // id hit outside the groups is forwarded as is
   if (!(cfg_hit || dma_hit || mmu_hit))
      return 1'b1;
   if (pkt.write)
   begin
      if (cfg_hit) model_cfg[pkt.dstaddr[5:2]] = pkt.data;
      if (dma_hit) model_dma[pkt.dstaddr[4:2]] = pkt.data;
      if (mmu_hit) model_mmu[pkt.dstaddr[7:3]] = {pkt.srcaddr, pkt.data};
      return 1'b0;
   end
   if (cfg_hit) rdata = {32'h0, model_cfg[pkt.dstaddr[5:2]]};
   if (dma_hit) rdata = {32'h0, model_dma[pkt.dstaddr[4:2]]};
   if (mmu_hit) rdata = model_mmu[pkt.dstaddr[7:3]];
   // readback goes to the requester
   exp_pkt.write   = 1'b1;
   exp_pkt.dstaddr = pkt.srcaddr;
   exp_pkt.srcaddr = rdata[63:32];
   exp_pkt.data    = rdata[31:0];
   return 1'b1;
endfunction

`endif

// File: bench/cfg_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_subsystem_tb
   import emesh_pkg::*;
();

   localparam chip_id_t chip_id       = 12'h810;
   localparam bit       rx            = 1'b0;
   localparam int       reset_cycles  = 10;
   localparam int       run_cycles    = 3000;
   localparam int       drain_timeout = 50;

   // packet kinds for the stimulus
   localparam int k_write   = 0;
   localparam int k_read    = 1;
   localparam int k_forward = 2;
   localparam int k_foreign = 3;
   localparam int k_rx1     = 4;

   logic          clk = 1'b0;
   logic          reset;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_in;
   logic          access_out;
   emesh_packet_t packet_out;

   logic [31:0]   lfsr_state;
   emesh_packet_t exp_q [$];
   // wait_in as the dut saw it at the last edge
   logic          prev_wait;
   logic          held_access;
   emesh_packet_t held_packet;

   `include "cfg_model.svh"

   cfg_subsystem #(
      .chip_id (chip_id),
      .rx      (rx)
   ) i_dut (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   always #4 clk = ~clk;

   task automatic report_mismatch(input string name, input logic [103:0] expected,
                                  input logic [103:0] actual);
      $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("TEST FAIL");
      $fatal(1, "stopped on a failure");
   endtask

   // galois lfsr with x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_step();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out)
      begin
         lfsr_state = lfsr_state ^ 32'h80200003;
      end
      return out;
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r = {r[30:0], lfsr_step()};
      end
      return r;
   endfunction

   // group 0 picks cfg and 1 picks dma, anything else mmu
   function automatic addr_t group_addr(input int group, input logic side);
      addr_t a;
      a = rand_bits(32);
      a[31:20] = chip_id;
      case (group)
         0:
         begin
            a[19:16] = region_cfg;
            a[10:8]  = {group_cfg_lsb2, side};
         end
         1:
         begin
            a[19:16] = region_cfg;
            a[10:8]  = group_dma;
            a[5]     = side;
         end
         default:
         begin
            a[19:16] = region_mmu;
            a[15]    = side;
         end
      endcase
      return a;
   endfunction

   function automatic emesh_packet_t make_packet(input int kind, input int group);
      emesh_packet_t pkt;
      logic [2:0]    region;
      logic [10:0]   flip;
      pkt.write    = rand_bits(1);
      pkt.datamode = rand_bits(2);
      pkt.ctrlmode = rand_bits(4);
      pkt.reserved = rand_bits(1);
      pkt.data     = rand_bits(32);
      pkt.srcaddr  = rand_bits(32);
      case (kind)
         k_write:
         begin
            pkt.dstaddr = group_addr(group, rx);
            pkt.write   = 1'b1;
         end
         k_read:
         begin
            pkt.dstaddr = group_addr(group, rx);
            pkt.write   = 1'b0;
         end
         k_forward:
         begin
            // regions 0 to 7 hold no group
            pkt.dstaddr          = rand_bits(32);
            pkt.dstaddr[31:20]   = chip_id;
            region               = rand_bits(3);
            pkt.dstaddr[19:16]   = {1'b0, region};
         end
         k_foreign:
         begin
            pkt.dstaddr        = group_addr(group, rx);
            flip               = rand_bits(11);
            pkt.dstaddr[31:20] = chip_id ^ {flip, 1'b1};
         end
         default:
         begin
            pkt.dstaddr = group_addr(group, ~rx);
         end
      endcase
      return pkt;
   endfunction

   // inputs change right after the rising edge
   task automatic drive(input logic acc, input emesh_packet_t pkt, input logic w);
      @(posedge clk);
      access_in <= acc;
      packet_in <= pkt;
      wait_in   <= w;
   endtask

   // checker on the falling edge where inputs and outputs are stable
   always @(negedge clk)
   begin : check_outputs
      emesh_packet_t expected;
      if (reset)
      begin
         assert (access_out === 1'b0)
            else report_mismatch("access_out", 104'h0, access_out);
         prev_wait   = 1'b1;
         held_access = 1'b0;
      end
      else
      begin
         if (!prev_wait)
         begin
            // output register loaded at the last edge
            if (exp_q.size() > 0)
            begin
               expected = exp_q.pop_front();
               assert (access_out === 1'b1)
                  else report_mismatch("access_out", 104'h1, access_out);
               assert (packet_out === expected)
                  else report_mismatch("packet_out", expected, packet_out);
            end
            else
            begin
               assert (access_out === 1'b0)
                  else report_mismatch("access_out", 104'h0, access_out);
            end
         end
         else
         begin
            // stalled outputs must hold
            assert (access_out === held_access)
               else report_mismatch("access_out", held_access, access_out);
            if (held_access)
            begin
               assert (packet_out === held_packet)
                  else report_mismatch("packet_out", held_packet, packet_out);
            end
         end
         held_access = access_out;
         held_packet = packet_out;
         // packet taken at the coming edge
         if (access_in && !wait_in)
         begin
            if (model_apply(packet_in, chip_id, rx, expected))
            begin
               exp_q.push_back(expected);
            end
         end
         prev_wait = wait_in;
      end
   end

   initial
   begin : stimulus
      emesh_packet_t wr_pkt;
      emesh_packet_t rd_pkt;
      logic          w;
      int            sel;
      int            kind;
      reset      = 1'b1;
      access_in  = 1'b0;
      packet_in  = '0;
      wait_in    = 1'b0;
      lfsr_state = 32'd29;
      model_reset();
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;
      drive(1'b0, packet_in, 1'b0);

      // reads before any write and then a write and readback per group
      for (int g = 0; g < 3; g++)
      begin
         drive(1'b1, make_packet(k_read, g), 1'b0);
      end
      for (int g = 0; g < 3; g++)
      begin
         wr_pkt = make_packet(k_write, g);
         rd_pkt = wr_pkt;
         rd_pkt.write   = 1'b0;
         rd_pkt.srcaddr = rand_bits(32);
         drive(1'b1, wr_pkt, 1'b0);
         drive(1'b1, rd_pkt, 1'b0);
      end

      // readback held under a stall
      drive(1'b1, make_packet(k_read, 2), 1'b0);
      repeat (3) drive(1'b0, packet_in, 1'b1);
      drive(1'b0, packet_in, 1'b0);

      // forward followed by foreign id and rx side 1 packets
      drive(1'b1, make_packet(k_forward, 0), 1'b0);
      for (int g = 0; g < 3; g++)
      begin
         drive(1'b1, make_packet(k_foreign, g), 1'b0);
         drive(1'b1, make_packet(k_rx1, g), 1'b0);
      end

      // random run
      for (int c = 0; c < run_cycles; c++)
      begin
         w   = (rand_bits(2) == 32'd3);
         sel = rand_bits(3);
         if (w || sel < 2)
         begin
            drive(1'b0, packet_in, w);
         end
         else
         begin
            kind = (sel == 7) ? k_read : sel - 2;
            drive(1'b1, make_packet(kind, rand_bits(2)), 1'b0);
         end
      end

      // let the last packet leave
      for (int i = 0; i < drain_timeout && (exp_q.size() != 0 || access_out); i++)
      begin
         drive(1'b0, packet_in, 1'b0);
      end
      if (exp_q.size() != 0 || access_out)
      begin
         report_failure("timeout while waiting for the expected packets to drain");
      end
      else
      begin
         @(negedge clk);
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: logic/cfg_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_subsystem
   import emesh_pkg::*;
#(
   parameter chip_id_t chip_id = 12'h810,
   parameter bit       rx      = 1'b0
)
(
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic          access_in,
   input  wire emesh_packet_t packet_in,
   input  wire logic          wait_in,
   output logic               access_out,
   output emesh_packet_t      packet_out
);

   logic      cfg_en;
   logic      dma_en;
   logic      mmu_en;
   mi_bus_t   mi_bus;
   mi_rdata_t cfg_rdata;
   mi_rdata_t dma_rdata;
   mi_rdata_t mmu_rdata;

   // decoder and output stage
   cfg_access #(
      .chip_id (chip_id),
      .rx      (rx)
   ) i_access (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .cfg_rdata  (cfg_rdata),
      .dma_rdata  (dma_rdata),
      .mmu_rdata  (mmu_rdata),
      .cfg_en     (cfg_en),
      .dma_en     (dma_en),
      .mmu_en     (mmu_en),
      .mi_bus     (mi_bus),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   // register groups share the bus, each has its own select
   cfg_regs i_cfg_regs (
      .clk    (clk),
      .reset  (reset),
      .en     (cfg_en),
      .mi_bus (mi_bus),
      .rdata  (cfg_rdata)
   );

   dma_regs i_dma_regs (
      .clk    (clk),
      .reset  (reset),
      .en     (dma_en),
      .mi_bus (mi_bus),
      .rdata  (dma_rdata)
   );

   mmu_table i_mmu_table (
      .clk    (clk),
      .reset  (reset),
      .en     (mmu_en),
      .mi_bus (mi_bus),
      .rdata  (mmu_rdata)
   );

endmodule

`default_nettype wire

// File: logic/mmu_table.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_table
   import emesh_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    reset,
   input  wire logic    en,
   input  wire mi_bus_t mi_bus,
   output mi_rdata_t    rdata
);

   localparam int depth = 32;

   // 64-bit entries, one per 8-byte address step
   logic [63:0] table_q [depth];
   logic [4:0]  index;

   assign index = mi_bus.addr[7:3];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < depth; i++)
         begin
            table_q[i] <= '0;
         end
      end
      else if (en && mi_bus.we)
      begin
         // srcaddr and data together fill one entry
         table_q[index] <= mi_bus.din;
      end
   end

   // full entry back, zero when not selected
   always_comb
   begin
      if (en)
      begin
         rdata = table_q[index];
      end
      else
      begin
         rdata = '0;
      end
   end

endmodule

`default_nettype wire

// File: logic/dma_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_regs
   import emesh_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    reset,
   input  wire logic    en,
   input  wire mi_bus_t mi_bus,
   output mi_rdata_t    rdata
);

   localparam int depth = 8;

   data_t      regs [depth];
   logic [2:0] index;

   // bit 5 picks the rx side, so the index stops at bit 4
   assign index = mi_bus.addr[4:2];

   // storage only, no dma engine behind it
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < depth; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (en && mi_bus.we)
      begin
         regs[index] <= mi_bus.din[31:0];
      end
   end

   // gated read, upper half zero
   always_comb
   begin
      if (en)
      begin
         rdata = {32'h0, regs[index]};
      end
      else
      begin
         rdata = '0;
      end
   end

endmodule

`default_nettype wire

// File: logic/cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
   import emesh_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    reset,
   // group select from the decoder
   input  wire logic    en,
   input  wire mi_bus_t mi_bus,
   // zero unless selected
   output mi_rdata_t    rdata
);

   localparam int depth = 16;

   data_t      regs [depth];
   logic [3:0] index;

   // word index from addr[5:2]
   assign index = mi_bus.addr[5:2];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < depth; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (en && mi_bus.we)
      begin
         // only the data half of din is kept
         regs[index] <= mi_bus.din[31:0];
      end
   end

   // 32-bit registers, upper half of the answer is zero
   always_comb
   begin
      if (en)
      begin
         rdata = {32'h0, regs[index]};
      end
      else
      begin
         rdata = '0;
      end
   end

endmodule

`default_nettype wire

// File: logic/cfg_access.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_access
   import emesh_pkg::*;
#(
   parameter chip_id_t chip_id = 12'h810,
   parameter bit       rx      = 1'b0
)
(
   input  wire logic          clk,
   input  wire logic          reset,
   // incoming packet, one-cycle strobe
   input  wire logic          access_in,
   input  wire emesh_packet_t packet_in,
   // downstream stall
   input  wire logic          wait_in,
   // group answers
   input  wire mi_rdata_t     cfg_rdata,
   input  wire mi_rdata_t     dma_rdata,
   input  wire mi_rdata_t     mmu_rdata,
   // group selects and write bus
   output logic               cfg_en,
   output logic               dma_en,
   output logic               mmu_en,
   output mi_bus_t            mi_bus,
   // outgoing packet
   output logic               access_out,
   output emesh_packet_t      packet_out
);

   logic          match;
   logic          any_en;
   logic          rd;
   logic          fwd;
   mi_rdata_t     rdata;
   emesh_packet_t readback;
   emesh_packet_t forward;

   // id match on the top twelve address bits
   assign match = access_in && (packet_in.dstaddr[31:20] == chip_id);

   // config group, rx side in bit 8
   assign cfg_en = match
                   && (packet_in.dstaddr[19:16] == region_cfg)
                   && (packet_in.dstaddr[10:8] == {group_cfg_lsb2, rx});

   // dma group, rx side in bit 5
   assign dma_en = match
                   && (packet_in.dstaddr[19:16] == region_cfg)
                   && (packet_in.dstaddr[10:8] == group_dma)
                   && (packet_in.dstaddr[5] == rx);

   // mmu region, rx side in bit 15
   assign mmu_en = match
                   && (packet_in.dstaddr[19:16] == region_mmu)
                   && (packet_in.dstaddr[15] == rx);

   assign any_en = cfg_en || dma_en || mmu_en;

   // read returns a packet, write is silent
   assign rd = any_en && !packet_in.write;

   // id hit outside the groups goes on to the other direction
   assign fwd = match && !any_en;

   // write bus
   always_comb
   begin
      mi_bus.we   = packet_in.write && any_en;
      mi_bus.addr = packet_in.dstaddr[14:0];
      mi_bus.din  = {packet_in.srcaddr, packet_in.data};
   end

   // unselected groups answer zero, so a plain or is enough
   assign rdata = cfg_rdata | dma_rdata | mmu_rdata;

   // readback goes back to the requester
   always_comb
   begin
      readback          = packet_in;
      readback.write    = 1'b1;
      readback.reserved = 1'b0;
      readback.dstaddr  = packet_in.srcaddr;
      readback.srcaddr  = rdata[63:32];
      readback.data     = rdata[31:0];
   end

   // forward keeps everything but the reserved bit
   always_comb
   begin
      forward          = packet_in;
      forward.reserved = 1'b0;
   end

   // output valid, frozen under wait_in
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         access_out <= 1'b0;
      end
      else if (!wait_in)
      begin
         access_out <= rd || fwd;
      end
   end

   // output payload
   // only loaded on an accepted read or forward
   always_ff @(posedge clk)
   begin
      if (!wait_in && (rd || fwd))
      begin
         packet_out <= rd ? readback : forward;
      end
   end

endmodule

`default_nettype wire

// File: logic/emesh_pkg.sv
`default_nettype none

package emesh_pkg;

   // mesh address and data word
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // chip id, compared with dstaddr[31:20]
   typedef logic [11:0] chip_id_t;

   // readback word from a register group, zero when not selected
   typedef logic [63:0] mi_rdata_t;

   // 104-bit mesh packet, msb first
   typedef struct packed {
      logic       write;
      logic [1:0] datamode;
      logic [3:0] ctrlmode;
      logic       reserved;
      addr_t      dstaddr;
      data_t      data;
      addr_t      srcaddr;
   } emesh_packet_t;

   // register write side, shared by all groups
   typedef struct packed {
      logic        we;
      logic [14:0] addr;
      // srcaddr in the upper half, data in the lower
      logic [63:0] din;
   } mi_bus_t;

   // upper two bits of the cfg group field, rx side is the lsb
   localparam logic [1:0] group_cfg_lsb2 = 2'b01;

   // dma group in dstaddr[10:8]
   localparam logic [2:0] group_dma = 3'h5;

   // region field in dstaddr[19:16]
   localparam logic [3:0] region_cfg = 4'hF;
   localparam logic [3:0] region_mmu = 4'hE;

endpackage

`default_nettype wire
